//--- Bender.yml
package:
  name: dcp

sources:
  - dcp_pkg.sv
  - cpu_view_pkg.sv
  - dcp_scan.sv
  - dcp_print.sv
  - dcp_cmd_mem.sv
  - dcp_cmd_reg.sv
  - dcp_cmd_pc.sv
  - dcp.sv
  - target: simulation
    files:
      - tb_dcp.sv

//--- all.f
dcp_pkg.sv
cpu_view_pkg.sv
dcp_scan.sv
dcp_print.sv
dcp_cmd_mem.sv
dcp_cmd_reg.sv
dcp_cmd_pc.sv
dcp.sv
tb_dcp.sv

//--- cpu_view_pkg.sv
package cpu_view_pkg;

    localparam int word_w = 32; // every cpu word and the address bus

    // register file seen through addr
    localparam int rf_depth = 32;
    localparam int rf_aw    = $clog2(rf_depth);

    // pc npc ir ctl a b y mdr
    localparam int pc_words = 8;
    localparam int pc_cw    = $clog2(pc_words);

endpackage

//--- dcp.sv
module dcp (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [7:0]                        d_rx,
    input  logic                              vld_rx,
    output logic                              rdy_rx,
    output logic [7:0]                        d_tx,
    output logic                              vld_tx,
    input  logic                              rdy_tx,
    input  logic [cpu_view_pkg::word_w-1:0]   pc,
    input  logic [cpu_view_pkg::word_w-1:0]   npc,
    input  logic [cpu_view_pkg::word_w-1:0]   ir,
    input  logic [cpu_view_pkg::word_w-1:0]   ctl,
    input  logic [cpu_view_pkg::word_w-1:0]   a,
    input  logic [cpu_view_pkg::word_w-1:0]   b,
    input  logic [cpu_view_pkg::word_w-1:0]   y,
    input  logic [cpu_view_pkg::word_w-1:0]   mdr,
    input  logic [cpu_view_pkg::word_w-1:0]   dout_rf,
    input  logic [cpu_view_pkg::word_w-1:0]   dout_dm,
    input  logic [cpu_view_pkg::word_w-1:0]   dout_im,
    output logic [cpu_view_pkg::word_w-1:0]   addr
);

    logic                             req_rx, type_rx, ack_rx, flag_rx;
    dcp_pkg::scan_word_u              din_rx;
    logic                             req_tx, type_tx, ack_tx;
    logic [cpu_view_pkg::word_w-1:0]  dout_tx;

    logic [1:0] state;
    logic [7:0] sel_mode;
    logic       finish;
    logic [7:0] chr;

    logic                             req_rx_mem, type_rx_mem, req_tx_mem, type_tx_mem;
    logic                             finish_mem;
    logic [cpu_view_pkg::word_w-1:0]  dout_mem, addr_mem;
    logic                             req_tx_reg, type_tx_reg, finish_reg;
    logic [cpu_view_pkg::word_w-1:0]  dout_reg, addr_reg;
    logic                             req_tx_pc, type_tx_pc, finish_pc;
    logic [cpu_view_pkg::word_w-1:0]  dout_pc;

    dcp_scan i_scan (
        .clk(clk), .rstn(rstn),
        .d_rx(d_rx), .vld_rx(vld_rx), .rdy_rx(rdy_rx),
        .req_rx(req_rx), .type_rx(type_rx),
        .ack_rx(ack_rx), .flag_rx(flag_rx), .din_rx(din_rx)
    );

    dcp_print i_print (
        .clk(clk), .rstn(rstn),
        .d_tx(d_tx), .vld_tx(vld_tx), .rdy_tx(rdy_tx),
        .req_tx(req_tx), .type_tx(type_tx),
        .dout_tx(dout_tx), .ack_tx(ack_tx)
    );

    dcp_cmd_mem i_cmd_mem (
        .clk(clk), .rstn(rstn), .sel_mode(sel_mode),
        .din_rx(din_rx), .ack_rx(ack_rx), .flag_rx(flag_rx), .ack_tx(ack_tx),
        .req_rx(req_rx_mem), .type_rx(type_rx_mem),
        .req_tx(req_tx_mem), .type_tx(type_tx_mem),
        .dout(dout_mem), .addr(addr_mem), .finish(finish_mem),
        .dout_dm(dout_dm), .dout_im(dout_im)
    );

    dcp_cmd_reg i_cmd_reg (
        .clk(clk), .rstn(rstn), .sel_mode(sel_mode), .ack_tx(ack_tx),
        .req_tx(req_tx_reg), .type_tx(type_tx_reg),
        .dout(dout_reg), .addr(addr_reg), .finish(finish_reg),
        .dout_rf(dout_rf)
    );

    dcp_cmd_pc i_cmd_pc (
        .clk(clk), .rstn(rstn), .sel_mode(sel_mode), .ack_tx(ack_tx),
        .req_tx(req_tx_pc), .type_tx(type_tx_pc),
        .dout(dout_pc), .finish(finish_pc),
        .pc(pc), .npc(npc), .ir(ir), .ctl(ctl),
        .a(a), .b(b), .y(y), .mdr(mdr)
    );

    assign chr = din_rx.chr.code;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state    <= dcp_pkg::st_init;
            sel_mode <= dcp_pkg::mode_init;
        end
        else
        begin
            case (state)
                dcp_pkg::st_init:
                begin
                    sel_mode <= dcp_pkg::mode_init;
                    state    <= dcp_pkg::st_first;
                end
                dcp_pkg::st_first:
                begin
                    if (ack_rx)
                    begin
                        if (!flag_rx && (chr == dcp_pkg::cmd_p || chr == dcp_pkg::cmd_r ||
                                         chr == dcp_pkg::cmd_d || chr == dcp_pkg::cmd_i))
                            sel_mode <= chr;
                        else
                            sel_mode <= dcp_pkg::mode_fail;
                        state <= dcp_pkg::st_wait;
                    end
                end
                default:
                begin
                    // clear mode with finish so the unit does not restart
                    if (finish)
                    begin
                        sel_mode <= dcp_pkg::mode_init;
                        state    <= dcp_pkg::st_init;
                    end
                end
            endcase
        end
    end

    // route the selected unit onto scanner, printer and cpu address
    always_comb
    begin
        req_rx  = 1'b0;
        type_rx = 1'b0;
        req_tx  = 1'b0;
        type_tx = 1'b0;
        dout_tx = '0;
        addr    = '0;
        finish  = 1'b1; // init and fail
        case (sel_mode)
            dcp_pkg::mode_init:
                req_rx = (state == dcp_pkg::st_first); // char scan for command
            dcp_pkg::cmd_d, dcp_pkg::cmd_i:
            begin
                req_rx  = req_rx_mem;
                type_rx = type_rx_mem;
                req_tx  = req_tx_mem;
                type_tx = type_tx_mem;
                dout_tx = dout_mem;
                addr    = addr_mem;
                finish  = finish_mem;
            end
            dcp_pkg::cmd_r:
            begin
                req_tx  = req_tx_reg;
                type_tx = type_tx_reg;
                dout_tx = dout_reg;
                addr    = addr_reg;
                finish  = finish_reg;
            end
            dcp_pkg::cmd_p:
            begin
                req_tx  = req_tx_pc;
                type_tx = type_tx_pc;
                dout_tx = dout_pc;
                finish  = finish_pc;
            end
            default:
                finish = 1'b1;
        endcase
    end

endmodule

//--- dcp_cmd_mem.sv
module dcp_cmd_mem (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [7:0]                        sel_mode,
    input  dcp_pkg::scan_word_u               din_rx,
    input  logic                              ack_rx,
    input  logic                              flag_rx,
    input  logic                              ack_tx,
    output logic                              req_rx,
    output logic                              type_rx,
    output logic                              req_tx,
    output logic                              type_tx,
    output logic [cpu_view_pkg::word_w-1:0]   dout,
    output logic [cpu_view_pkg::word_w-1:0]   addr,
    output logic                              finish,
    input  logic [cpu_view_pkg::word_w-1:0]   dout_dm,
    input  logic [cpu_view_pkg::word_w-1:0]   dout_im
);

    logic scan_on;
    logic samp; // memory read settles this cycle
    logic prt_on;
    logic start;

    assign start = (sel_mode == dcp_pkg::cmd_d || sel_mode == dcp_pkg::cmd_i)
                   && !(scan_on || samp || prt_on || finish);

    assign req_rx  = scan_on;
    assign type_rx = scan_on; // address comes as hex
    assign req_tx  = prt_on;
    assign type_tx = prt_on;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            scan_on <= 1'b0;
            samp    <= 1'b0;
            prt_on  <= 1'b0;
            finish  <= 1'b0;
            addr    <= '0;
        end
        else
        begin
            finish <= 1'b0;
            samp   <= 1'b0;
            if (start)
                scan_on <= 1'b1;
            if (scan_on && ack_rx)
            begin
                scan_on <= 1'b0;
                if (flag_rx)
                    finish <= 1'b1; // bad argument, no output
                else
                begin
                    addr <= din_rx.value;
                    samp <= 1'b1;
                end
            end
            if (samp)
                prt_on <= 1'b1;
            if (prt_on && ack_tx)
            begin
                prt_on <= 1'b0;
                finish <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (samp)
            dout <= (sel_mode == dcp_pkg::cmd_i) ? dout_im : dout_dm;
    end

endmodule

//--- dcp_cmd_pc.sv
module dcp_cmd_pc (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [7:0]                        sel_mode,
    input  logic                              ack_tx,
    output logic                              req_tx,
    output logic                              type_tx,
    output logic [cpu_view_pkg::word_w-1:0]   dout,
    output logic                              finish,
    input  logic [cpu_view_pkg::word_w-1:0]   pc,
    input  logic [cpu_view_pkg::word_w-1:0]   npc,
    input  logic [cpu_view_pkg::word_w-1:0]   ir,
    input  logic [cpu_view_pkg::word_w-1:0]   ctl,
    input  logic [cpu_view_pkg::word_w-1:0]   a,
    input  logic [cpu_view_pkg::word_w-1:0]   b,
    input  logic [cpu_view_pkg::word_w-1:0]   y,
    input  logic [cpu_view_pkg::word_w-1:0]   mdr
);

    logic                             run;
    logic                             prt_on;
    logic [cpu_view_pkg::pc_cw-1:0]   cnt;

    assign req_tx  = prt_on;
    assign type_tx = prt_on;

    // pipeline words are static while printing
    always_comb
    begin
        case (cnt)
            3'd0:    dout = pc;
            3'd1:    dout = npc;
            3'd2:    dout = ir;
            3'd3:    dout = ctl;
            3'd4:    dout = a;
            3'd5:    dout = b;
            3'd6:    dout = y;
            default: dout = mdr;
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            run    <= 1'b0;
            prt_on <= 1'b0;
            finish <= 1'b0;
            cnt    <= '0;
        end
        else
        begin
            finish <= 1'b0;
            if (sel_mode == dcp_pkg::cmd_p && !run && !finish)
            begin
                run <= 1'b1;
                cnt <= '0;
            end
            else if (run && !prt_on)
                prt_on <= 1'b1; // one idle cycle between requests
            else if (prt_on && ack_tx)
            begin
                prt_on <= 1'b0;
                if (cnt == cpu_view_pkg::pc_words - 1)
                begin
                    run    <= 1'b0;
                    finish <= 1'b1;
                end
                else
                    cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

//--- dcp_cmd_reg.sv
module dcp_cmd_reg (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [7:0]                        sel_mode,
    input  logic                              ack_tx,
    output logic                              req_tx,
    output logic                              type_tx,
    output logic [cpu_view_pkg::word_w-1:0]   dout,
    output logic [cpu_view_pkg::word_w-1:0]   addr,
    output logic                              finish,
    input  logic [cpu_view_pkg::word_w-1:0]   dout_rf
);

    logic                             run;
    logic                             prt_on;
    logic [cpu_view_pkg::rf_aw-1:0]   idx;

    assign addr    = {{(cpu_view_pkg::word_w - cpu_view_pkg::rf_aw){1'b0}}, idx};
    assign req_tx  = prt_on;
    assign type_tx = prt_on;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            run    <= 1'b0;
            prt_on <= 1'b0;
            finish <= 1'b0;
            idx    <= '0;
        end
        else
        begin
            finish <= 1'b0;
            if (sel_mode == dcp_pkg::cmd_r && !run && !finish)
            begin
                run <= 1'b1;
                idx <= '0;
            end
            else if (run && !prt_on)
                prt_on <= 1'b1; // dout_rf latched in this cycle
            else if (prt_on && ack_tx)
            begin
                prt_on <= 1'b0;
                if (idx == cpu_view_pkg::rf_depth - 1)
                begin
                    run    <= 1'b0;
                    finish <= 1'b1;
                end
                else
                    idx <= idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (run && !prt_on)
            dout <= dout_rf;
    end

endmodule

//--- dcp_pkg.sv
package dcp_pkg;

    // command characters
    localparam logic [7:0] cmd_p = 8'h50;
    localparam logic [7:0] cmd_r = 8'h52;
    localparam logic [7:0] cmd_d = 8'h44;
    localparam logic [7:0] cmd_i = 8'h49;

    localparam logic [7:0] mode_init = 8'h00;
    localparam logic [7:0] mode_fail = 8'hFF; // unknown first char

    // top level panel states
    localparam logic [1:0] st_init  = 2'd0;
    localparam logic [1:0] st_first = 2'd1; // fetch command char
    localparam logic [1:0] st_wait  = 2'd2; // unit running

    localparam logic [7:0] chr_0  = 8'h30;
    localparam logic [7:0] chr_9  = 8'h39;
    localparam logic [7:0] chr_au = 8'h41; // 'A'
    localparam logic [7:0] chr_fu = 8'h46;
    localparam logic [7:0] chr_al = 8'h61; // 'a'
    localparam logic [7:0] chr_fl = 8'h66;
    localparam logic [7:0] chr_cr = 8'h0D;
    localparam logic [7:0] chr_sp = 8'h20;
    localparam logic [7:0] chr_nl = 8'h0A;

    typedef struct packed {
        logic [23:0] pad;
        logic [7:0]  code;
    } scan_chr_t;

    // one scanned token, hex word or single character
    typedef union packed {
        logic [31:0] value;
        scan_chr_t   chr;
    } scan_word_u;

endpackage

//--- dcp_print.sv
module dcp_print (
    input  logic        clk,
    input  logic        rstn,
    output logic [7:0]  d_tx,
    output logic        vld_tx,
    input  logic        rdy_tx,
    input  logic        req_tx,
    input  logic        type_tx,
    input  logic [31:0] dout_tx,
    output logic        ack_tx
);

    logic       busy;
    logic [3:0] cnt; // byte index, 8 is the newline
    logic [3:0] nib;
    logic       last;

    assign last   = type_tx ? (cnt == 4'd8) : 1'b1;
    assign vld_tx = busy;

    always_comb
    begin
        nib = dout_tx[4 * (3'd7 - cnt[2:0]) +: 4]; // msb digit first
        if (!type_tx)
            d_tx = dout_tx[7:0];
        else if (cnt == 4'd8)
            d_tx = dcp_pkg::chr_nl;
        else if (nib < 4'd10)
            d_tx = dcp_pkg::chr_0 + {4'h0, nib};
        else
            d_tx = dcp_pkg::chr_au + {4'h0, nib} - 8'd10;
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            busy   <= 1'b0;
            cnt    <= 4'd0;
            ack_tx <= 1'b0;
        end
        else
        begin
            ack_tx <= 1'b0;
            if (!busy)
            begin
                // req is still up during ack
                if (req_tx && !ack_tx)
                begin
                    busy <= 1'b1;
                    cnt  <= 4'd0;
                end
            end
            else if (rdy_tx)
            begin
                if (last)
                begin
                    busy   <= 1'b0;
                    ack_tx <= 1'b1;
                end
                else
                begin
                    cnt <= cnt + 4'd1;
                end
            end
        end
    end

endmodule

//--- dcp_scan.sv
module dcp_scan (
    input  logic                clk,
    input  logic                rstn,
    input  logic [7:0]          d_rx,
    input  logic                vld_rx,
    output logic                rdy_rx,
    input  logic                req_rx,
    input  logic                type_rx,
    output logic                ack_rx,
    output logic                flag_rx,
    output dcp_pkg::scan_word_u din_rx
);

    logic       is_hex;
    logic       is_term;
    logic [3:0] nib;

    // ascii hex digit to nibble
    always_comb
    begin
        is_hex = 1'b1;
        nib    = 4'h0;
        if (d_rx >= dcp_pkg::chr_0 && d_rx <= dcp_pkg::chr_9)
            nib = 4'(d_rx - dcp_pkg::chr_0);
        else if (d_rx >= dcp_pkg::chr_au && d_rx <= dcp_pkg::chr_fu)
            nib = 4'(d_rx - dcp_pkg::chr_au + 8'd10);
        else if (d_rx >= dcp_pkg::chr_al && d_rx <= dcp_pkg::chr_fl)
            nib = 4'(d_rx - dcp_pkg::chr_al + 8'd10);
        else
            is_hex = 1'b0;
    end

    assign is_term = (d_rx == dcp_pkg::chr_cr) || (d_rx == dcp_pkg::chr_sp);

    // no byte taken in the ack cycle
    assign rdy_rx = req_rx && !ack_rx;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            ack_rx  <= 1'b0;
            flag_rx <= 1'b0;
            din_rx  <= '0;
        end
        else if (ack_rx)
        begin
            ack_rx <= 1'b0;
            din_rx <= '0; // next token starts from zero
        end
        else if (vld_rx && rdy_rx)
        begin
            if (!type_rx)
            begin
                din_rx.chr.pad  <= '0;
                din_rx.chr.code <= d_rx;
                flag_rx         <= 1'b0;
                ack_rx          <= 1'b1;
            end
            else if (is_hex)
            begin
                din_rx.value <= {din_rx.value[27:0], nib}; // old top digit drops out
            end
            else
            begin
                flag_rx <= !is_term; // bad char ends token too
                ack_rx  <= 1'b1;
            end
        end
    end

endmodule

//--- tb_dcp.sv
module tb_dcp;

    localparam int tmo = 2000; // cycles allowed for any single wait

    logic        clk = 1'b0;
    logic        rstn;
    logic [7:0]  d_rx;
    logic        vld_rx;
    logic        rdy_rx;
    logic [7:0]  d_tx;
    logic        vld_tx;
    logic        rdy_tx = 1'b0;
    logic [31:0] pipe_w [8];
    logic [31:0] dout_rf, dout_dm, dout_im, addr;

    logic [7:0] rx_q [$];
    logic       bp_on;
    int         stall = 0;
    int         checks = 0;
    int         errors = 0;
    logic       timed_out = 1'b0;

    always #2 clk = ~clk;

    dcp i_dcp (
        .clk(clk), .rstn(rstn),
        .d_rx(d_rx), .vld_rx(vld_rx), .rdy_rx(rdy_rx),
        .d_tx(d_tx), .vld_tx(vld_tx), .rdy_tx(rdy_tx),
        .pc(pipe_w[0]), .npc(pipe_w[1]), .ir(pipe_w[2]), .ctl(pipe_w[3]),
        .a(pipe_w[4]), .b(pipe_w[5]), .y(pipe_w[6]), .mdr(pipe_w[7]),
        .dout_rf(dout_rf), .dout_dm(dout_dm), .dout_im(dout_im), .addr(addr)
    );

    // cpu side models
    assign dout_rf = {27'd0, addr[4:0]} * 32'h01010101;
    assign dout_dm = addr ^ 32'hDA7A0000;
    assign dout_im = addr + 32'h10000000;

    always @(posedge clk)
    begin
        if (rstn && vld_tx && rdy_tx)
            rx_q.push_back(d_tx);
    end

    // receiver ready drops for random stretches when bp_on
    task automatic drive_ready();
        forever
        begin
            @(negedge clk);
            if (stall > 0)
            begin
                stall  = stall - 1;
                rdy_tx = 1'b0;
            end
            else if (bp_on && ($urandom % 4 == 0))
            begin
                stall  = $urandom % 7;
                rdy_tx = 1'b0;
            end
            else
                rdy_tx = 1'b1;
        end
    endtask

    function automatic logic [7:0] hex_digit(input logic [3:0] n, input logic lower);
        logic [7:0] c;
        if (n < 4'd10)
            c = 8'h30 + n;
        else
            c = (lower ? 8'h61 : 8'h41) + n - 8'd10;
        return c;
    endfunction

    // eight upper case digits then newline
    function automatic logic [71:0] hex_line(input logic [31:0] w);
        logic [71:0] l;
        l = {64'd0, 8'h0A};
        for (int i = 0; i < 8; i++)
            l[71 - 8 * i -: 8] = hex_digit(w[31 - 4 * i -: 4], 1'b0);
        return l;
    endfunction

    task automatic send_byte(input logic [7:0] b);
        int   n;
        logic took;
        if (timed_out)
            return;
        @(negedge clk);
        d_rx   = b;
        vld_rx = 1'b1;
        took   = 1'b0;
        n      = 0;
        while (!took && n < tmo)
        begin
            @(posedge clk);
            took = rdy_rx;
            n++;
        end
        @(negedge clk);
        vld_rx = 1'b0;
        if (!took)
        begin
            $display("timeout: DUT never took byte %02h", b);
            timed_out = 1'b1;
        end
    endtask

    task automatic send_hex(input logic [31:0] v, input int extra, input logic mixed);
        for (int i = 0; i < extra; i++)
            send_byte(hex_digit(4'($urandom), 1'($urandom)));
        for (int i = 0; i < 8; i++)
            send_byte(hex_digit(v[31 - 4 * i -: 4], mixed ? 1'($urandom) : 1'b0));
    endtask

    task automatic get_line(output logic [71:0] l);
        int n;
        l = '0;
        n = 0;
        while (rx_q.size() < 9 && n < tmo && !timed_out)
        begin
            @(negedge clk);
            n++;
        end
        if (rx_q.size() < 9)
        begin
            if (!timed_out)
                $display("timeout: a full output line never arrived");
            timed_out = 1'b1;
        end
        else
            for (int i = 0; i < 9; i++)
                l = {l[63:0], rx_q.pop_front()};
    endtask

    task automatic check_line(input logic [31:0] w, input int k);
        logic [71:0] got;
        logic [71:0] exp;
        exp = hex_line(w);
        get_line(got);
        if (timed_out)
            return;
        checks++;
        assert (got == exp)
        else
        begin
            $display("error at %0t: line %0d got %s (end %02h), expected %s",
                     $time, k, got[71:8], got[7:0], exp[71:8]);
            errors++;
        end
    endtask

    // waits for command fetch with nothing left over
    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while (!rdy_rx && n < tmo && !timed_out)
        begin
            @(negedge clk);
            n++;
        end
        if (!rdy_rx && !timed_out)
        begin
            $display("timeout: DUT did not return to command fetch after %s", what);
            timed_out = 1'b1;
        end
        if (timed_out)
            return;
        checks++;
        assert (rx_q.size() == 0)
        else
        begin
            $display("error at %0t: %0d extra bytes after %s", $time, rx_q.size(), what);
            errors++;
        end
    endtask

    task automatic report(input string name, input int e0);
        if (errors == e0 && !timed_out)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors, timeout %0d", name, errors - e0, timed_out);
    endtask

    initial
    begin
        logic [31:0] adr;
        int          e0;
        void'($urandom(32'he5ae));
        rstn   = 1'b0;
        d_rx   = 8'h00;
        vld_rx = 1'b0;
        bp_on  = 1'b0;
        foreach (pipe_w[i])
            pipe_w[i] = $urandom;
        fork
            drive_ready();
        join_none
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        e0 = errors;
        checks++;
        assert (!vld_tx && !rdy_rx && addr == '0)
        else
        begin
            $display("error at %0t: vld_tx, rdy_rx or addr not clear after reset", $time);
            errors++;
        end
        send_byte(8'h50);
        for (int k = 0; k < 8; k++)
            check_line(pipe_w[k], k);
        wait_idle("P");
        report("reset and P", e0);

        e0 = errors;
        send_byte(8'h52);
        for (int k = 0; k < 32; k++)
            check_line(k * 32'h01010101, k);
        wait_idle("R");
        report("R", e0);

        e0 = errors;
        adr = $urandom;
        send_byte(8'h44);
        send_hex(adr, 2, 1'b1); // leading digits drop out
        send_byte(8'h0D);
        check_line(adr ^ 32'hDA7A0000, 0);
        wait_idle("D");
        report("D", e0);

        e0 = errors;
        adr = $urandom;
        send_byte(8'h49);
        send_hex(adr, 0, 1'b0);
        send_byte(8'h20);
        check_line(adr + 32'h10000000, 0);
        wait_idle("I");
        report("I", e0);

        e0 = errors;
        send_byte(8'h58); // 'X' is no command
        wait_idle("bad command");
        adr = $urandom;
        send_byte(8'h44);
        send_hex(adr, 0, 1'b1);
        send_byte(8'h0D);
        check_line(adr ^ 32'hDA7A0000, 0);
        wait_idle("D after bad command");
        send_byte(8'h44);
        send_byte(8'h31);
        send_byte(8'h32);
        send_byte(8'h67); // 'g' ends the token flagged
        wait_idle("bad D argument");
        adr = $urandom;
        send_byte(8'h49);
        send_hex(adr, 1, 1'b1);
        send_byte(8'h20);
        check_line(adr + 32'h10000000, 0);
        wait_idle("I after bad argument");
        report("rejects", e0);

        e0 = errors;
        bp_on = 1'b1;
        send_byte(8'h50);
        for (int k = 0; k < 8; k++)
            check_line(pipe_w[k], k);
        wait_idle("P under back-pressure");
        send_byte(8'h52);
        for (int k = 0; k < 32; k++)
            check_line(k * 32'h01010101, k);
        wait_idle("R under back-pressure");
        adr = $urandom;
        send_byte(8'h44);
        send_hex(adr, 3, 1'b1);
        send_byte(8'h20);
        check_line(adr ^ 32'hDA7A0000, 0);
        wait_idle("D under back-pressure");
        bp_on = 1'b0;
        report("back-pressure", e0);

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
